//--- common/core_isa_pkg.sv
// Instruction set package: field widths and positions, opcode and ALU operation encodings
package core_isa_pkg;

    localparam int INSTRUCTION_WIDTH = 16;
    localparam int OPCODE_WIDTH = 4;
    localparam int REG_ADDR_WIDTH = 4;
    localparam int IMMEDIATE_WIDTH = 12;
    localparam int REGS_PER_CHANNEL = 16;

    // Lowest bit of each instruction field
    localparam int OPCODE_LSB = 0;
    localparam int FIELD_A_LSB = 4;
    localparam int FIELD_B_LSB = 8;
    localparam int FIELD_DEST_LSB = 12;
    localparam int IMMEDIATE_LSB = 4;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        MUL  = 4'd3,
        LDR  = 4'd4,
        LAND = 4'd5,
        LOR  = 4'd6,
        LNOT = 4'd7,
        BGT  = 4'd8,
        BLE  = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        STOP = 4'd12
    } opcode_t;

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_MUL = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_NOT = 4'd5,
        OP_GT  = 4'd6,
        OP_LE  = 4'd7,
        OP_EQ  = 4'd8,
        OP_NE  = 4'd9,
        OP_IMM = 4'd10
    } alu_op_t;

endpackage

//--- logic/alu.sv
// Registered integer ALU with control alignment stage
module alu #(
    parameter int DATAPATH_WIDTH = 16,
    parameter int MAX_CHANNELS = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic operation_valid,
    input  core_isa_pkg::alu_op_t alu_op,
    input  logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] dest_address,
    input  logic [core_isa_pkg::IMMEDIATE_WIDTH-1:0] immediate,
    input  logic [DATAPATH_WIDTH-1:0] operand_a_data,
    input  logic [DATAPATH_WIDTH-1:0] operand_b_data,
    output logic result_valid,
    output logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] result_address,
    output logic [DATAPATH_WIDTH-1:0] result_data
);

    localparam int ADDR_WIDTH = core_isa_pkg::REG_ADDR_WIDTH + $clog2(MAX_CHANNELS);

    logic valid_q;
    core_isa_pkg::alu_op_t op_q;
    logic [ADDR_WIDTH-1:0] dest_q;
    logic [core_isa_pkg::IMMEDIATE_WIDTH-1:0] immediate_q;
    logic [DATAPATH_WIDTH-1:0] result;

    always_comb begin
        case (op_q)
            core_isa_pkg::OP_ADD: result = operand_a_data + operand_b_data;
            core_isa_pkg::OP_SUB: result = operand_a_data - operand_b_data;
            core_isa_pkg::OP_MUL: result = operand_a_data * operand_b_data;
            core_isa_pkg::OP_AND: result = operand_a_data & operand_b_data;
            core_isa_pkg::OP_OR:  result = operand_a_data | operand_b_data;
            core_isa_pkg::OP_NOT: result = ~operand_a_data;
            core_isa_pkg::OP_GT:  result = DATAPATH_WIDTH'(operand_a_data > operand_b_data);
            core_isa_pkg::OP_LE:  result = DATAPATH_WIDTH'(operand_a_data <= operand_b_data);
            core_isa_pkg::OP_EQ:  result = DATAPATH_WIDTH'(operand_a_data == operand_b_data);
            core_isa_pkg::OP_NE:  result = DATAPATH_WIDTH'(operand_a_data != operand_b_data);
            core_isa_pkg::OP_IMM: result = DATAPATH_WIDTH'(immediate_q);
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            valid_q <= operation_valid;
            result_valid <= valid_q;
        end
    end

    // Control waits here one cycle for the register file read data
    always_ff @(posedge clock) begin
        op_q <= alu_op;
        dest_q <= dest_address;
        immediate_q <= immediate;
        result_address <= dest_q;
        result_data <= result;
    end

endmodule

//--- logic/register_file.sv
// Channel-banked register file with two operand read ports, a host read port and one write port
module register_file #(
    parameter int DATAPATH_WIDTH = 16,
    parameter int MAX_CHANNELS = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] read_a_address,
    input  logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] read_b_address,
    input  logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] read_host_address,
    output logic [DATAPATH_WIDTH-1:0] read_a_data,
    output logic [DATAPATH_WIDTH-1:0] read_b_data,
    output logic [DATAPATH_WIDTH-1:0] read_host_data,
    input  logic write,
    input  logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] write_address,
    input  logic [DATAPATH_WIDTH-1:0] write_data
);

    localparam int DEPTH = MAX_CHANNELS * core_isa_pkg::REGS_PER_CHANNEL;

    logic [DATAPATH_WIDTH-1:0] registers [DEPTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                registers[i] <= '0;
            end
        end else if (write) begin
            registers[write_address] <= write_data;
        end
    end

    // Reads see the value from before a write on the same edge
    always_ff @(posedge clock) begin
        read_a_data <= registers[read_a_address];
        read_b_data <= registers[read_b_address];
        read_host_data <= registers[read_host_address];
    end

endmodule

//--- logic/program_sequencer.sv
// Program sequencer: program memory, program counter, channel loop and pipeline drain
module program_sequencer #(
    parameter int MAX_CHANNELS = 4,
    parameter int PROGRAM_DEPTH = 64
) (
    input  logic clock,
    input  logic reset,
    input  logic prog_write,
    input  logic [$clog2(PROGRAM_DEPTH)-1:0] prog_address,
    input  logic [core_isa_pkg::INSTRUCTION_WIDTH-1:0] prog_data,
    input  logic start,
    input  logic [$clog2(MAX_CHANNELS):0] n_channels,
    input  logic core_stop,
    output logic [core_isa_pkg::INSTRUCTION_WIDTH-1:0] instruction,
    output logic enable,
    output logic [$clog2(MAX_CHANNELS)-1:0] channel_address,
    output logic busy,
    output logic done
);

    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH);
    localparam int CHANNEL_WIDTH = $clog2(MAX_CHANNELS);

    logic [core_isa_pkg::INSTRUCTION_WIDTH-1:0] program_memory [PROGRAM_DEPTH];
    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] fetch_address;
    logic [CHANNEL_WIDTH:0] n_channels_q;
    logic [2:0] drain_count;
    logic running;
    logic fetch_valid;
    logic last_channel;

    // A stop restarts the fetch at word 0 straight away for the next channel
    assign fetch_address = core_stop ? '0 : pc;
    assign last_channel = {1'b0, channel_address} + 1'b1 >= n_channels_q;
    // The word fetched behind STOP is squashed here
    assign enable = fetch_valid & ~core_stop;

    always_ff @(posedge clock) begin
        if (prog_write) begin
            program_memory[prog_address] <= prog_data;
        end
        instruction <= program_memory[fetch_address];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            channel_address <= '0;
            n_channels_q <= '0;
            drain_count <= '0;
            running <= 1'b0;
            fetch_valid <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            fetch_valid <= running & ~(core_stop & last_channel);
            if (running) begin
                pc <= fetch_address + 1'b1;
            end
            if (start && !busy) begin
                busy <= 1'b1;
                running <= 1'b1;
                pc <= '0;
                channel_address <= '0;
                n_channels_q <= n_channels;
            end else if (core_stop) begin
                if (last_channel) begin
                    running <= 1'b0;
                    drain_count <= 3'd4;
                end else begin
                    channel_address <= channel_address + 1'b1;
                end
            end else if (drain_count != '0) begin
                drain_count <= drain_count - 1'b1;
                if (drain_count == 3'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- decoder/instruction_decoder.sv
// Instruction decoder: field split, channel banking of register fields, ALU operation mapping
module instruction_decoder #(
    parameter int MAX_CHANNELS = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic [core_isa_pkg::INSTRUCTION_WIDTH-1:0] instruction,
    input  logic [$clog2(MAX_CHANNELS)-1:0] channel_address,
    output logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] operand_a_address,
    output logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] operand_b_address,
    output logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] dest_address,
    output core_isa_pkg::alu_op_t alu_op,
    output logic [core_isa_pkg::IMMEDIATE_WIDTH-1:0] immediate,
    output logic operation_valid,
    output logic core_stop
);

    localparam int FIELD_WIDTH = core_isa_pkg::REG_ADDR_WIDTH;
    localparam int ADDR_WIDTH = FIELD_WIDTH + $clog2(MAX_CHANNELS);

    core_isa_pkg::opcode_t opcode;
    logic [ADDR_WIDTH-1:0] bank_base;
    logic [ADDR_WIDTH-1:0] address_a;
    logic [ADDR_WIDTH-1:0] address_b;
    logic [ADDR_WIDTH-1:0] address_dest;
    logic [core_isa_pkg::IMMEDIATE_WIDTH-1:0] field_immediate;
    core_isa_pkg::alu_op_t decoded_op;
    logic [ADDR_WIDTH-1:0] decoded_dest;
    logic decoded_valid;

    assign opcode = core_isa_pkg::opcode_t'(
        instruction[core_isa_pkg::OPCODE_LSB +: core_isa_pkg::OPCODE_WIDTH]);
    assign field_immediate =
        instruction[core_isa_pkg::IMMEDIATE_LSB +: core_isa_pkg::IMMEDIATE_WIDTH];

    // Each channel sees its own bank of 16 registers
    assign bank_base = ADDR_WIDTH'(channel_address) * ADDR_WIDTH'(core_isa_pkg::REGS_PER_CHANNEL);
    assign address_a = bank_base
        + ADDR_WIDTH'(instruction[core_isa_pkg::FIELD_A_LSB +: FIELD_WIDTH]);
    assign address_b = bank_base
        + ADDR_WIDTH'(instruction[core_isa_pkg::FIELD_B_LSB +: FIELD_WIDTH]);
    assign address_dest = bank_base
        + ADDR_WIDTH'(instruction[core_isa_pkg::FIELD_DEST_LSB +: FIELD_WIDTH]);

    always_comb begin
        decoded_op = core_isa_pkg::OP_ADD;
        decoded_dest = address_dest;
        decoded_valid = 1'b1;
        case (opcode)
            core_isa_pkg::ADD:  decoded_op = core_isa_pkg::OP_ADD;
            core_isa_pkg::SUB:  decoded_op = core_isa_pkg::OP_SUB;
            core_isa_pkg::MUL:  decoded_op = core_isa_pkg::OP_MUL;
            core_isa_pkg::LAND: decoded_op = core_isa_pkg::OP_AND;
            core_isa_pkg::LOR:  decoded_op = core_isa_pkg::OP_OR;
            core_isa_pkg::BGT:  decoded_op = core_isa_pkg::OP_GT;
            core_isa_pkg::BLE:  decoded_op = core_isa_pkg::OP_LE;
            core_isa_pkg::BEQ:  decoded_op = core_isa_pkg::OP_EQ;
            core_isa_pkg::BNE:  decoded_op = core_isa_pkg::OP_NE;
            // Single operand forms reuse the free register fields as destination
            core_isa_pkg::LNOT: begin
                decoded_op = core_isa_pkg::OP_NOT;
                decoded_dest = address_b;
            end
            core_isa_pkg::LDR: begin
                decoded_op = core_isa_pkg::OP_IMM;
                decoded_dest = address_a;
            end
            default: decoded_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || !enable) begin
            operand_a_address <= '0;
            operand_b_address <= '0;
            dest_address <= '0;
            alu_op <= core_isa_pkg::OP_ADD;
            immediate <= '0;
            operation_valid <= 1'b0;
            core_stop <= 1'b0;
        end else begin
            operand_a_address <= address_a;
            operand_b_address <= address_b;
            dest_address <= decoded_dest;
            alu_op <= decoded_op;
            immediate <= field_immediate;
            operation_valid <= decoded_valid;
            core_stop <= opcode == core_isa_pkg::STOP;
        end
    end

endmodule

//--- logic/dsp_core.sv
// Top level of the multi-channel core: sequencer, decoder, register file, ALU, host write mux
module dsp_core #(
    parameter int DATAPATH_WIDTH = 16,
    parameter int MAX_CHANNELS = 4,
    parameter int PROGRAM_DEPTH = 64
) (
    input  logic clock,
    input  logic reset,
    input  logic prog_write,
    input  logic [$clog2(PROGRAM_DEPTH)-1:0] prog_address,
    input  logic [core_isa_pkg::INSTRUCTION_WIDTH-1:0] prog_data,
    input  logic host_write,
    input  logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] host_address,
    input  logic [DATAPATH_WIDTH-1:0] host_data,
    input  logic [core_isa_pkg::REG_ADDR_WIDTH+$clog2(MAX_CHANNELS)-1:0] read_address,
    output logic [DATAPATH_WIDTH-1:0] read_data,
    input  logic start,
    input  logic [$clog2(MAX_CHANNELS):0] n_channels,
    output logic busy,
    output logic done
);

    localparam int ADDR_WIDTH = core_isa_pkg::REG_ADDR_WIDTH + $clog2(MAX_CHANNELS);

    logic [core_isa_pkg::INSTRUCTION_WIDTH-1:0] instruction;
    logic enable;
    logic [$clog2(MAX_CHANNELS)-1:0] channel_address;
    logic core_stop;
    logic [ADDR_WIDTH-1:0] operand_a_address;
    logic [ADDR_WIDTH-1:0] operand_b_address;
    logic [ADDR_WIDTH-1:0] dest_address;
    core_isa_pkg::alu_op_t alu_op;
    logic [core_isa_pkg::IMMEDIATE_WIDTH-1:0] immediate;
    logic operation_valid;
    logic [DATAPATH_WIDTH-1:0] operand_a_data;
    logic [DATAPATH_WIDTH-1:0] operand_b_data;
    logic result_valid;
    logic [ADDR_WIDTH-1:0] result_address;
    logic [DATAPATH_WIDTH-1:0] result_data;
    logic rf_write;
    logic [ADDR_WIDTH-1:0] rf_write_address;
    logic [DATAPATH_WIDTH-1:0] rf_write_data;

    // The host owns the write port whenever no program is running
    assign rf_write = busy ? result_valid : host_write;
    assign rf_write_address = busy ? result_address : host_address;
    assign rf_write_data = busy ? result_data : host_data;

    program_sequencer #(
        .MAX_CHANNELS(MAX_CHANNELS),
        .PROGRAM_DEPTH(PROGRAM_DEPTH)
    ) sequencer (
        .clock(clock),
        .reset(reset),
        .prog_write(prog_write),
        .prog_address(prog_address),
        .prog_data(prog_data),
        .start(start),
        .n_channels(n_channels),
        .core_stop(core_stop),
        .instruction(instruction),
        .enable(enable),
        .channel_address(channel_address),
        .busy(busy),
        .done(done)
    );

    instruction_decoder #(
        .MAX_CHANNELS(MAX_CHANNELS)
    ) decoder (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .instruction(instruction),
        .channel_address(channel_address),
        .operand_a_address(operand_a_address),
        .operand_b_address(operand_b_address),
        .dest_address(dest_address),
        .alu_op(alu_op),
        .immediate(immediate),
        .operation_valid(operation_valid),
        .core_stop(core_stop)
    );

    register_file #(
        .DATAPATH_WIDTH(DATAPATH_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) registers (
        .clock(clock),
        .reset(reset),
        .read_a_address(operand_a_address),
        .read_b_address(operand_b_address),
        .read_host_address(read_address),
        .read_a_data(operand_a_data),
        .read_b_data(operand_b_data),
        .read_host_data(read_data),
        .write(rf_write),
        .write_address(rf_write_address),
        .write_data(rf_write_data)
    );

    alu #(
        .DATAPATH_WIDTH(DATAPATH_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) execution_unit (
        .clock(clock),
        .reset(reset),
        .operation_valid(operation_valid),
        .alu_op(alu_op),
        .dest_address(dest_address),
        .immediate(immediate),
        .operand_a_data(operand_a_data),
        .operand_b_data(operand_b_data),
        .result_valid(result_valid),
        .result_address(result_address),
        .result_data(result_data)
    );

endmodule

//--- bench/dsp_core_tb.sv
// Testbench for dsp_core: reads the cases file, loads programs and registers, runs and checks
module dsp_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATAPATH_WIDTH = 16;
    localparam int MAX_CHANNELS = 4;
    localparam int PROGRAM_DEPTH = 64;
    localparam int ADDR_WIDTH = core_isa_pkg::REG_ADDR_WIDTH + $clog2(MAX_CHANNELS);
    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH);
    localparam int CHANNEL_COUNT_WIDTH = $clog2(MAX_CHANNELS) + 1;

    logic clock;
    logic reset;
    logic prog_write;
    logic [PC_WIDTH-1:0] prog_address;
    logic [core_isa_pkg::INSTRUCTION_WIDTH-1:0] prog_data;
    logic host_write;
    logic [ADDR_WIDTH-1:0] host_address;
    logic [DATAPATH_WIDTH-1:0] host_data;
    logic [ADDR_WIDTH-1:0] read_address;
    logic [DATAPATH_WIDTH-1:0] read_data;
    logic start;
    logic [CHANNEL_COUNT_WIDTH-1:0] n_channels;
    logic busy;
    logic done;

    string case_name = "none";
    int program_words = 0;
    int cycle_count = 0;
    int deadline = 0;
    logic waiting = 1'b0;

    dsp_core #(
        .DATAPATH_WIDTH(DATAPATH_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS),
        .PROGRAM_DEPTH(PROGRAM_DEPTH)
    ) uut (
        .clock(clock),
        .reset(reset),
        .prog_write(prog_write),
        .prog_address(prog_address),
        .prog_data(prog_data),
        .host_write(host_write),
        .host_address(host_address),
        .host_data(host_data),
        .read_address(read_address),
        .read_data(read_data),
        .start(start),
        .n_channels(n_channels),
        .busy(busy),
        .done(done)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // A run gets 20 cycles plus 8 per program word and channel
    always @(posedge clock) begin
        if (waiting && cycle_count > deadline) begin
            abort_run($sformatf("timeout in case %s: done never arrived", case_name));
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic read_number(input int fd, input bit hex, output int value);
        int status;
        if (hex) begin
            status = $fscanf(fd, "%h", value);
        end else begin
            status = $fscanf(fd, "%d", value);
        end
        if (status != 1) begin
            abort_run("the cases file ends in the middle of a line");
        end
    endtask

    task automatic skip_line(input int fd);
        int character;
        character = $fgetc(fd);
        while (character != 10 && character != -1) begin
            character = $fgetc(fd);
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (!busy && !done) else begin
            abort_run($sformatf("busy or done is high after reset in case %s", case_name));
        end
    endtask

    task automatic load_word(input int address, input int word);
        prog_write = 1'b1;
        prog_address = PC_WIDTH'(address);
        prog_data = core_isa_pkg::INSTRUCTION_WIDTH'(word);
        @(negedge clock);
        prog_write = 1'b0;
    endtask

    task automatic write_register(input int address, input int value);
        host_write = 1'b1;
        host_address = ADDR_WIDTH'(address);
        host_data = DATAPATH_WIDTH'(value);
        @(negedge clock);
        host_write = 1'b0;
    endtask

    task automatic run_program(input int channels);
        start = 1'b1;
        n_channels = CHANNEL_COUNT_WIDTH'(channels);
        @(negedge clock);
        start = 1'b0;
        assert (busy) else begin
            abort_run($sformatf("busy did not rise after start in case %s", case_name));
        end
        deadline = cycle_count + 20 + 8 * program_words * channels;
        waiting = 1'b1;
        while (!done) begin
            @(negedge clock);
        end
        waiting = 1'b0;
        // Done and the falling edge of busy come from the same clock edge
        assert (!busy) else begin
            abort_run($sformatf("busy still high while done pulses in case %s", case_name));
        end
    endtask

    task automatic check_register(input int address, input int expected);
        logic [DATAPATH_WIDTH-1:0] expected_value;
        expected_value = DATAPATH_WIDTH'(expected);
        read_address = ADDR_WIDTH'(address);
        @(negedge clock);
        assert (read_data === expected_value) else begin
            abort_run($sformatf("error: case %s register %h expected %h actual %h",
                case_name, read_address, expected_value, read_data));
        end
    endtask

    initial begin
        int fd;
        int count;
        int address;
        int value;
        string keyword;
        clock = 1'b0;
        reset = 1'b1;
        prog_write = 1'b0;
        prog_address = '0;
        prog_data = '0;
        host_write = 1'b0;
        host_address = '0;
        host_data = '0;
        read_address = '0;
        start = 1'b0;
        n_channels = '0;
        fd = $fopen("bench/core_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/core_cases.txt");
        end
        while ($fscanf(fd, "%s", keyword) == 1) begin
            if (keyword == "#") begin
                skip_line(fd);
            end else if (keyword == "case") begin
                void'($fscanf(fd, "%s", case_name));
                program_words = 0;
                apply_reset();
            end else if (keyword == "prog") begin
                read_number(fd, 1'b0, count);
                program_words = count;
                for (int i = 0; i < count; i++) begin
                    read_number(fd, 1'b1, value);
                    load_word(i, value);
                end
            end else if (keyword == "reg") begin
                read_number(fd, 1'b1, address);
                read_number(fd, 1'b0, count);
                for (int i = 0; i < count; i++) begin
                    read_number(fd, 1'b1, value);
                    write_register(address + i, value);
                end
            end else if (keyword == "run") begin
                read_number(fd, 1'b0, count);
                run_program(count);
            end else if (keyword == "check") begin
                read_number(fd, 1'b1, address);
                read_number(fd, 1'b0, count);
                for (int i = 0; i < count; i++) begin
                    read_number(fd, 1'b1, value);
                    check_register(address + i, value);
                end
            end else begin
                abort_run($sformatf("unknown line kind %s in the cases file", keyword));
            end
        end
        $fclose(fd);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- bench/core_cases.txt
# Line kinds: case name, prog count words (from address 0), reg address count values,
# run channels, check address count values; counts and channels decimal, all else hex
case arith
prog 10 3211 8541 9452 a212 b763 c713 0000 0000 0000 000c
reg 01 7 1234 0f0f 0000 fff0 0020 8000 0003
run 1
check 01 12 1234 0f0f 2143 fff0 0020 8000 0003 0010 0030 0325 8000 369c
# Everything written by the previous case must be cleared by reset
case reset_state
check 00 13 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
check 30 2 0000 0000
# LNOT reads field a and writes field b, its dest field is ignored
case logic
prog 8 8215 9216 5637 0747 0000 0000 0000 000c
reg 01 6 f0f0 3c3c 1234 00ff aaaa 5555
run 1
check 00 10 0000 f0f0 3c3c 1234 00ff aaaa edcb ff00 3030 fcfc
case compare
prog 14 6218 7219 821a 921b a418 b419 c41a d319 e31b f458 0000 0000 0000 000c
reg 01 15 0005 0005 0003 0009 8000 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff
run 1
check 06 10 0000 0001 0001 0000 0000 0001 0000 0000 0001 0001
# Three channels with their own r1, bank 3 stays untouched
case banking
prog 10 1024 ab54 0000 0000 3211 6152 0000 0000 0000 000c
reg 01 1 0010
reg 11 1 0100
reg 21 1 f000
reg 31 1 7777
run 3
check 01 6 0010 0102 0112 0000 0ab5 0aa5
check 11 6 0100 0102 0202 0000 0ab5 09b5
check 21 6 f000 0102 f102 0000 0ab5 1ab5
check 31 6 7777 0000 0000 0000 0000 0000
# Words after STOP would write r7 and r8
case stop_flush
prog 7 1144 0000 0000 0000 000c 7211 3c84
reg 01 2 0001 0002
reg 07 1 5a5a
run 1
check 04 5 0114 0000 0000 5a5a 0000
reg 04 1 0000
reg 17 1 5a5a
run 2
check 04 5 0114 0000 0000 5a5a 0000
check 14 4 0114 0000 0000 5a5a

//--- files.f
common/core_isa_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/program_sequencer.sv
decoder/instruction_decoder.sv
logic/dsp_core.sv
bench/dsp_core_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module dsp_core_tb -f files.f
	./obj_dir/Vdsp_core_tb

clean:
	rm -rf obj_dir
